// File: common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and address width
`define CPU_XLEN 32

// General register file
`define CPU_REG_COUNT 32
`define CPU_REG_BITS 5

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: common/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  // MIPS opcode encodings
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_slt = 6'h2a
  } funct_e;

  // Low 16 bits double as immediate and low 26 as jump index
  typedef struct packed {
    logic [5:0]               opcode;
    logic [`CPU_REG_BITS-1:0] rs;
    logic [`CPU_REG_BITS-1:0] rt;
    logic [`CPU_REG_BITS-1:0] rd;
    logic [4:0]               shamt;
    logic [5:0]               funct;
  } instr_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_mem_access,
    st_write_back
  } state_e;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    reg_dst_rd;
    logic    mem_to_reg;
    logic    pc_write;
    logic    branch;
    logic    branch_ne;
    logic    jump;
    logic    bus_req;
    logic    bus_we;
    logic    bus_ifetch;
    logic    ir_write;
  } ctrl_t;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`CPU_XLEN-1:0] adr;
    logic [`CPU_XLEN-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`CPU_XLEN-1:0] dat_r;
  } wb_rsp_t;

endpackage

// File: control/cpu_control.sv
module cpu_control (
  input  logic            clock,
  input  logic            reset,
  input  cpu_pkg::instr_t instr,
  input  logic            bus_done,
  output cpu_pkg::ctrl_t  ctrl
);

  cpu_pkg::state_e  state;
  cpu_pkg::state_e  next_state;
  cpu_pkg::alu_op_e rtype_op;
  logic             rtype_ok;
  logic             is_rtype;
  logic             is_addi;
  logic             is_load;
  logic             is_store;
  logic             is_beq;
  logic             is_bne;
  logic             is_jump;
  logic             known;

  // Instruction decode
  always_comb begin
    is_rtype = instr.opcode == cpu_pkg::op_rtype;
    is_addi  = instr.opcode == cpu_pkg::op_addi;
    is_load  = instr.opcode == cpu_pkg::op_lw;
    is_store = instr.opcode == cpu_pkg::op_sw;
    is_beq   = instr.opcode == cpu_pkg::op_beq;
    is_bne   = instr.opcode == cpu_pkg::op_bne;
    is_jump  = instr.opcode == cpu_pkg::op_j;

    rtype_op = cpu_pkg::alu_add;
    rtype_ok = 1'b1;
    case (instr.funct)
      cpu_pkg::fn_add: rtype_op = cpu_pkg::alu_add;
      cpu_pkg::fn_sub: rtype_op = cpu_pkg::alu_sub;
      cpu_pkg::fn_and: rtype_op = cpu_pkg::alu_and;
      cpu_pkg::fn_slt: rtype_op = cpu_pkg::alu_slt;
      default:         rtype_ok = 1'b0;
    endcase

    known = (is_rtype && rtype_ok) || is_addi || is_load || is_store ||
            is_beq || is_bne || is_jump;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::st_fetch;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    ctrl = '0;
    next_state = state;

    // ALU setup follows the instruction, so the result stays valid
    // from execute through write_back while IR and registers hold
    if (is_rtype) begin
      ctrl.alu_op = rtype_op;
    end else if (is_beq || is_bne) begin
      ctrl.alu_op = cpu_pkg::alu_sub;
    end else begin
      ctrl.alu_op = cpu_pkg::alu_add;
    end
    ctrl.alu_src_imm = is_addi | is_load | is_store;
    ctrl.reg_dst_rd  = is_rtype;
    ctrl.mem_to_reg  = is_load;
    ctrl.branch_ne   = is_bne;

    case (state)
      cpu_pkg::st_fetch: begin
        ctrl.bus_req    = 1'b1;
        ctrl.bus_ifetch = 1'b1;
        // PC+4 and IR land on the ack edge
        ctrl.ir_write   = bus_done;
        ctrl.pc_write   = bus_done;
        if (bus_done) begin
          next_state = cpu_pkg::st_decode;
        end
      end

      cpu_pkg::st_decode: begin
        // Unknown codes fall back to fetch since PC already advanced
        next_state = known ? cpu_pkg::st_execute : cpu_pkg::st_fetch;
      end

      cpu_pkg::st_execute: begin
        ctrl.branch   = is_beq | is_bne;
        ctrl.jump     = is_jump;
        ctrl.pc_write = is_jump;
        if (is_load || is_store) begin
          next_state = cpu_pkg::st_mem_access;
        end else if (is_rtype || is_addi) begin
          next_state = cpu_pkg::st_write_back;
        end else begin
          next_state = cpu_pkg::st_fetch;
        end
      end

      cpu_pkg::st_mem_access: begin
        ctrl.bus_req = 1'b1;
        ctrl.bus_we  = is_store;
        if (bus_done) begin
          next_state = is_load ? cpu_pkg::st_write_back : cpu_pkg::st_fetch;
        end
      end

      cpu_pkg::st_write_back: begin
        ctrl.reg_write = 1'b1;
        next_state = cpu_pkg::st_fetch;
      end

      default: begin
        next_state = cpu_pkg::st_fetch;
      end
    endcase
  end

endmodule

// File: design/pc_unit.sv
`include "cpu_settings.svh"

module pc_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  cpu_pkg::ctrl_t       ctrl,
  input  cpu_pkg::instr_t      instr,
  input  logic                 zero,
  output logic [`CPU_XLEN-1:0] pc
);

  logic [`CPU_XLEN-1:0] pc_plus4;
  logic [`CPU_XLEN-1:0] branch_target;
  logic [`CPU_XLEN-1:0] jump_target;
  logic [`CPU_XLEN-1:0] next_pc;
  logic                 take_branch;

  assign pc_plus4 = pc + 4;

  // PC already points past the branch here
  assign branch_target = pc + {{(`CPU_XLEN-18){instr[15]}}, instr[15:0], 2'b00};
  assign jump_target   = {pc[`CPU_XLEN-1:28], instr[25:0], 2'b00};

  // beq wants zero, bne wants non-zero
  assign take_branch = ctrl.branch & (zero ^ ctrl.branch_ne);

  always_comb begin
    if (ctrl.jump) begin
      next_pc = jump_target;
    end else if (take_branch) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `CPU_RESET_PC;
    end else if (ctrl.pc_write || take_branch) begin
      pc <= next_pc;
    end
  end

endmodule

// File: design/reg_file.sv
`include "cpu_settings.svh"

module reg_file (
  input  logic                 clock,
  input  logic                 reset,
  input  cpu_pkg::ctrl_t       ctrl,
  input  cpu_pkg::instr_t      instr,
  input  logic [`CPU_XLEN-1:0] alu_result,
  input  logic [`CPU_XLEN-1:0] load_data,
  output logic [`CPU_XLEN-1:0] rs_data,
  output logic [`CPU_XLEN-1:0] rt_data
);

  logic [`CPU_XLEN-1:0]     regs [`CPU_REG_COUNT];
  logic [`CPU_REG_BITS-1:0] dest;
  logic [`CPU_XLEN-1:0]     wr_data;

  // rd for R type, rt for addi and lw
  assign dest    = ctrl.reg_dst_rd ? instr.rd : instr.rt;
  assign wr_data = ctrl.mem_to_reg ? load_data : alu_result;

  // Register 0 is never written
  always_ff @(posedge clock) begin
    if (!reset && ctrl.reg_write && dest != '0) begin
      regs[dest] <= wr_data;
    end
  end

  assign rs_data = (instr.rs == '0) ? '0 : regs[instr.rs];
  assign rt_data = (instr.rt == '0) ? '0 : regs[instr.rt];

endmodule

// File: design/alu.sv
`include "cpu_settings.svh"

module alu (
  input  cpu_pkg::ctrl_t       ctrl,
  input  cpu_pkg::instr_t      instr,
  input  logic [`CPU_XLEN-1:0] rs_data,
  input  logic [`CPU_XLEN-1:0] rt_data,
  output logic [`CPU_XLEN-1:0] result,
  output logic                 zero
);

  logic [`CPU_XLEN-1:0] imm_ext;
  logic [`CPU_XLEN-1:0] operand_b;

  assign imm_ext   = {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};
  assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  // Add wraps on overflow without a trap
  always_comb begin
    result = rs_data + operand_b;
    case (ctrl.alu_op)
      cpu_pkg::alu_sub: result = rs_data - operand_b;
      cpu_pkg::alu_and: result = rs_data & operand_b;
      cpu_pkg::alu_slt: begin
        result = '0;
        result[0] = $signed(rs_data) < $signed(operand_b);
      end
      default: result = rs_data + operand_b;
    endcase
  end

  // Branch compare uses sub
  assign zero = result == '0;

endmodule

// File: design/bus_master.sv
`include "cpu_settings.svh"

module bus_master (
  input  logic                 clock,
  input  logic                 reset,
  input  cpu_pkg::ctrl_t       ctrl,
  input  logic [`CPU_XLEN-1:0] pc,
  input  logic [`CPU_XLEN-1:0] addr,
  input  logic [`CPU_XLEN-1:0] store_data,
  output cpu_pkg::wb_req_t     wb_req,
  input  cpu_pkg::wb_rsp_t     wb_rsp,
  output cpu_pkg::instr_t      instr,
  output logic [`CPU_XLEN-1:0] load_data,
  output logic                 bus_done
);

  logic                 active;
  logic                 we_q;
  logic [`CPU_XLEN-1:0] adr_q;
  logic [`CPU_XLEN-1:0] dat_w_q;

  // One transfer at a time with an idle cycle after each ack
  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      we_q <= 1'b0;
    end else if (active) begin
      if (wb_rsp.ack) begin
        active <= 1'b0;
        we_q <= 1'b0;
      end
    end else if (ctrl.bus_req) begin
      active <= 1'b1;
      we_q <= ctrl.bus_we;
    end
  end

  // Request payload held stable for the whole cycle
  always_ff @(posedge clock) begin
    if (!active && ctrl.bus_req) begin
      adr_q <= ctrl.bus_ifetch ? pc : addr;
      dat_w_q <= store_data;
    end
  end

  assign bus_done = active & wb_rsp.ack;

  always_comb begin
    wb_req.cyc   = active;
    wb_req.stb   = active;
    wb_req.we    = we_q;
    wb_req.adr   = adr_q;
    wb_req.dat_w = dat_w_q;
  end

  always_ff @(posedge clock) begin
    if (ctrl.ir_write) begin
      instr <= cpu_pkg::instr_t'(wb_rsp.dat_r);
    end
    // lw data waits here for write_back
    if (bus_done && !ctrl.bus_ifetch && !we_q) begin
      load_data <= wb_rsp.dat_r;
    end
  end

endmodule

// File: design/cpu_top.sv
`include "cpu_settings.svh"

module cpu_top (
  input  logic             clock,
  input  logic             reset,
  output cpu_pkg::wb_req_t wb_req,
  input  cpu_pkg::wb_rsp_t wb_rsp
);

  cpu_pkg::ctrl_t       ctrl;
  cpu_pkg::instr_t      instr;
  logic                 bus_done;
  logic                 zero;
  logic [`CPU_XLEN-1:0] pc;
  logic [`CPU_XLEN-1:0] rs_data;
  logic [`CPU_XLEN-1:0] rt_data;
  logic [`CPU_XLEN-1:0] alu_result;
  logic [`CPU_XLEN-1:0] load_data;

  cpu_control control_i (
    .clock    (clock),
    .reset    (reset),
    .instr    (instr),
    .bus_done (bus_done),
    .ctrl     (ctrl)
  );

  pc_unit pc_unit_i (
    .clock (clock),
    .reset (reset),
    .ctrl  (ctrl),
    .instr (instr),
    .zero  (zero),
    .pc    (pc)
  );

  reg_file reg_file_i (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .instr      (instr),
    .alu_result (alu_result),
    .load_data  (load_data),
    .rs_data    (rs_data),
    .rt_data    (rt_data)
  );

  alu alu_i (
    .ctrl    (ctrl),
    .instr   (instr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .result  (alu_result),
    .zero    (zero)
  );

  // lw and sw address is base plus offset from the ALU
  bus_master bus_master_i (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .pc         (pc),
    .addr       (alu_result),
    .store_data (rt_data),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .instr      (instr),
    .load_data  (load_data),
    .bus_done   (bus_done)
  );

endmodule

// File: verif/cpu_props.sv
module cpu_props (
  input logic             clock,
  input logic             reset,
  input cpu_pkg::wb_req_t wb_req,
  input cpu_pkg::wb_rsp_t wb_rsp
);
  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  stb_needs_cyc: assert property (
    @(posedge clock) disable iff (reset) wb_req.stb |-> wb_req.cyc
  ) else begin
    failures++;
    $error("stb high while cyc is low");
  end

  // Request held until acked
  req_stable: assert property (
    @(posedge clock) disable iff (reset)
    (wb_req.stb && !wb_rsp.ack) |=>
      ($stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat_w))
  ) else begin
    failures++;
    $error("request changed before ack");
  end

  idle_after_reset: assert property (
    @(posedge clock) reset |=> !wb_req.cyc
  ) else begin
    failures++;
    $error("cyc high right after reset");
  end

endmodule

bind cpu_top cpu_props props_i (
  .clock  (clock),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp)
);

// File: verif/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [5:0] op_r = 6'h00;
  localparam logic [5:0] op_j = 6'h02;
  localparam logic [5:0] op_beq = 6'h04;
  localparam logic [5:0] op_bne = 6'h05;
  localparam logic [5:0] op_addi = 6'h08;
  localparam logic [5:0] op_lw = 6'h23;
  localparam logic [5:0] op_sw = 6'h2b;

  logic             clock;
  logic             reset;
  cpu_pkg::wb_req_t wb_req;
  cpu_pkg::wb_rsp_t wb_rsp;

  logic [31:0] image [256];
  logic [31:0] mem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          test_last [4] = '{4, 6, 9, 11};
  integer      seed = 32'h6ebaef53;
  int          wait_left;
  int          n_instr;
  int          cycle_limit;
  int          cycles;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          checks;
  int          stores_seen;
  int          test_idx;
  bit          first_seen;
  bit          final_ok;

  cpu_top dut_i (
    .clock  (clock),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  function automatic logic [31:0] enc_r(int rs, int rt, int rd, logic [5:0] funct);
    return {op_r, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] enc_j(int idx);
    return {op_j, idx[25:0]};
  endfunction

  // Instruction-level model that fills the expected store list
  function automatic int run_reference();
    logic [31:0] m [256];
    logic [31:0] r [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          count;
    bit          wr;
    count = 0;
    for (int i = 0; i < 256; i++) m[i] = image[i];
    for (int i = 0; i < 32; i++) r[i] = '0;
    pc = `CPU_RESET_PC;
    while (count < 1000) begin
      w = m[pc[9:2]];
      pc = pc + 4;
      count++;
      imm = {{16{w[15]}}, w[15:0]};
      a = r[w[25:21]];
      b = r[w[20:16]];
      wr = 1'b0;
      if (w[31:26] == op_j) begin
        if ({pc[31:28], w[25:0], 2'b00} == pc - 4) break;
        pc = {pc[31:28], w[25:0], 2'b00};
      end else if (w[31:26] == op_r) begin
        wr = 1'b1;
        case (w[5:0])
          6'h20: res = a + b;
          6'h22: res = a - b;
          6'h24: res = a & b;
          6'h2a: res = {31'd0, $signed(a) < $signed(b)};
          default: wr = 1'b0;
        endcase
        if (wr && w[15:11] != 0) r[w[15:11]] = res;
      end else if (w[31:26] == op_addi) begin
        if (w[20:16] != 0) r[w[20:16]] = a + imm;
      end else if (w[31:26] == op_lw) begin
        res = m[(a + imm) >> 2 & 32'hff];
        if (w[20:16] != 0) r[w[20:16]] = res;
      end else if (w[31:26] == op_sw) begin
        m[(a + imm) >> 2 & 32'hff] = b;
        exp_addr.push_back(a + imm);
        exp_data.push_back(b);
      end else if (w[31:26] == op_beq) begin
        if (a == b) pc = pc + (imm << 2);
      end else if (w[31:26] == op_bne) begin
        if (a != b) pc = pc + (imm << 2);
      end
    end
    return count;
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) image[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);
    // ALU ops with stores from 0x200
    image[0] = enc_i(op_addi, 0, 1, 7);
    image[1] = enc_i(op_addi, 0, 2, -3);
    image[2] = enc_r(1, 2, 3, 6'h20);
    image[3] = enc_i(op_sw, 0, 3, 'h200);
    image[4] = enc_r(2, 1, 4, 6'h22);
    image[5] = enc_i(op_sw, 0, 4, 'h204);
    image[6] = enc_r(1, 2, 5, 6'h24);
    image[7] = enc_i(op_sw, 0, 5, 'h208);
    image[8] = enc_r(2, 1, 6, 6'h2a);
    image[9] = enc_i(op_sw, 0, 6, 'h20c);
    image[10] = enc_r(1, 2, 7, 6'h2a);
    image[11] = enc_i(op_sw, 0, 7, 'h210);
    // Load and store round trip
    image[12] = enc_i(op_addi, 0, 8, -100);
    image[13] = enc_i(op_addi, 0, 9, 'h220);
    image[14] = enc_i(op_sw, 9, 8, -4);
    image[15] = enc_i(op_lw, 9, 10, -4);
    image[16] = enc_i(op_addi, 10, 10, 1);
    image[17] = enc_i(op_sw, 9, 10, 0);
    // Branches and jump
    image[18] = enc_i(op_beq, 1, 1, 1);
    image[19] = enc_i(op_sw, 0, 1, 'h224);
    image[20] = enc_i(op_beq, 1, 2, 1);
    image[21] = enc_i(op_sw, 0, 2, 'h228);
    image[22] = enc_i(op_bne, 1, 2, 1);
    image[23] = enc_i(op_sw, 0, 1, 'h22c);
    image[24] = enc_i(op_bne, 1, 1, 1);
    image[25] = enc_i(op_sw, 0, 1, 'h230);
    image[26] = enc_j(28);
    image[27] = enc_i(op_sw, 0, 2, 'h234);
    image[28] = enc_i(op_sw, 0, 5, 'h238);
    // r0 writes and unknown codes
    image[29] = enc_i(op_addi, 0, 0, 55);
    image[30] = enc_r(1, 1, 0, 6'h20);
    image[31] = enc_i(op_sw, 0, 0, 'h240);
    image[32] = 32'hfc21_0005;
    // Unknown funct targets r5, which feeds the next add
    image[33] = enc_r(1, 1, 5, 6'h3f);
    image[34] = enc_r(5, 1, 11, 6'h20);
    image[35] = enc_i(op_sw, 0, 11, 'h244);
    image[36] = enc_j(36);
    for (int i = 0; i < 256; i++) mem[i] = image[i];
  endtask

  // Memory model with 0 to 3 cycles of ack delay
  always @(posedge clock) begin
    #0.5;
    if (reset) begin
      wb_rsp = '0;
      wait_left = -1;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack = 1'b0;
      wait_left = -1;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (wait_left < 0) wait_left = $unsigned($random(seed)) % 4;
      if (wait_left == 0) begin
        if (wb_req.we) mem[wb_req.adr[9:2]] = wb_req.dat_w;
        wb_rsp.dat_r = mem[wb_req.adr[9:2]];
        wb_rsp.ack = 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  // Compare process samples mid-cycle where the bus is stable
  always @(negedge clock) begin
    if (!reset && !first_seen && wb_req.cyc) begin
      first_seen = 1'b1;
      check_value("first request we", {31'd0, wb_req.we}, 32'd0);
      check_value("first request adr", wb_req.adr, `CPU_RESET_PC);
      tests_run++;
      if (errors != 0) tests_failed++;
      $display("test 1 first fetch after reset: %s", errors == 0 ? "ok" : "failed");
      test_errors = errors;
    end
    if (!reset && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
      if (stores_seen >= exp_data.size()) begin
        errors++;
        $display("Unexpected extra store to %h at %0t", wb_req.adr, $time);
      end else begin
        check_value("store address", wb_req.adr, exp_addr[stores_seen]);
        check_value("store data", wb_req.dat_w, exp_data[stores_seen]);
        if (test_idx < 4 && stores_seen == test_last[test_idx]) begin
          tests_run++;
          if (errors != test_errors) tests_failed++;
          $display("test %0d store group: %s", test_idx + 2,
                   errors == test_errors ? "ok" : "failed");
          test_errors = errors;
          test_idx++;
        end
      end
      stores_seen++;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, only %0d stores seen", cycles, stores_seen);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    wb_rsp = '0;
    wait_left = -1;
    cycles = 0;
    cycle_limit = 0;
    errors = 0;
    test_errors = 0;
    checks = 0;
    stores_seen = 0;
    test_idx = 0;
    first_seen = 1'b0;
    final_ok = 1'b0;
    tests_run = 0;
    tests_failed = 0;
    load_program();
    n_instr = run_reference();
    cycle_limit = 40 * n_instr + 200;
    repeat (5) @(posedge clock);
    #0.5;
    reset = 1'b0;
    wait (stores_seen == exp_data.size());
    repeat (20) @(posedge clock);
    tests_run++;
    if (dut_i.props_i.failures != 0) begin
      $display("Bus protocol assertions failed %0d times", dut_i.props_i.failures);
    end
    final_ok = first_seen && stores_seen == exp_data.size() && errors == 0 &&
               dut_i.props_i.failures == 0;
    if (!final_ok) tests_failed++;
    $display("test 6 full store list under random ack delays: %s",
             final_ok ? "ok" : "failed");
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/cpu_pkg.sv
control/cpu_control.sv
design/pc_unit.sv
design/reg_file.sv
design/alu.sv
design/bus_master.sv
design/cpu_top.sv
verif/cpu_props.sv
verif/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f build.f \
  --top-module cpu_tb \
  --Mdir obj_dir \
  -o cpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
